// File: common/hazard_config.svh
`ifndef HAZARD_CONFIG_SVH
`define HAZARD_CONFIG_SVH

//////////////////////////////////////////////////
// Field widths shared by the hazard block
//////////////////////////////////////////////////

// Full MIPS instruction word
`define INSTR_W 32

// Register index, 32 architectural registers
`define REG_W 5

// Tuse / Tnew range is 0..2
`define T_W 2

`endif

// File: common/hazardPkg.sv
`include "hazard_config.svh"

package hazardPkg;

    // Register number, 0 means no dependency
    typedef logic [`REG_W-1:0] regIdx_t;

    // Cycles until a value is needed or ready
    typedef logic [`T_W-1:0] tTime_t;

    //////////////////////////////////////////////////
    // Opcodes
    //////////////////////////////////////////////////

    localparam logic [5:0] OP_R    = 6'b000000;
    localparam logic [5:0] OP_COP0 = 6'b010000;
    localparam logic [5:0] OP_ORI  = 6'b001101;
    localparam logic [5:0] OP_ADDI = 6'b001000;
    localparam logic [5:0] OP_ANDI = 6'b001100;
    localparam logic [5:0] OP_LUI  = 6'b001111;
    localparam logic [5:0] OP_LW   = 6'b100011;
    localparam logic [5:0] OP_LH   = 6'b100001;
    localparam logic [5:0] OP_LB   = 6'b100000;
    localparam logic [5:0] OP_SW   = 6'b101011;
    localparam logic [5:0] OP_SH   = 6'b101001;
    localparam logic [5:0] OP_SB   = 6'b101000;
    localparam logic [5:0] OP_BEQ  = 6'b000100;
    localparam logic [5:0] OP_BNE  = 6'b000101;
    localparam logic [5:0] OP_J    = 6'b000010;
    localparam logic [5:0] OP_JAL  = 6'b000011;

    //////////////////////////////////////////////////
    // Function codes
    //////////////////////////////////////////////////

    localparam logic [5:0] FN_ADD   = 6'b100000;
    localparam logic [5:0] FN_SUB   = 6'b100010;
    localparam logic [5:0] FN_AND   = 6'b100100;
    localparam logic [5:0] FN_OR    = 6'b100101;
    localparam logic [5:0] FN_SLT   = 6'b101010;
    localparam logic [5:0] FN_SLTU  = 6'b101011;
    localparam logic [5:0] FN_MULT  = 6'b011000;
    localparam logic [5:0] FN_MULTU = 6'b011001;
    localparam logic [5:0] FN_DIV   = 6'b011010;
    localparam logic [5:0] FN_DIVU  = 6'b011011;
    localparam logic [5:0] FN_MFHI  = 6'b010000;
    localparam logic [5:0] FN_MFLO  = 6'b010010;
    localparam logic [5:0] FN_MTHI  = 6'b010001;
    localparam logic [5:0] FN_MTLO  = 6'b010011;
    localparam logic [5:0] FN_JR    = 6'b001000;

    // Only meaningful under OP_COP0
    localparam logic [5:0] FN_ERET  = 6'b011000;

    // COP0 rs field selects move direction
    localparam logic [4:0] CP0_MF = 5'd0;
    localparam logic [4:0] CP0_MT = 5'd4;

endpackage

// File: hazard/useDecoder.sv
`timescale 1ns/1ps
`include "hazard_config.svh"

module useDecoder import hazardPkg::*; (
    input  logic [`INSTR_W-1:0] instrD,
    output regIdx_t             srcRs,
    output regIdx_t             srcRt,
    output tTime_t              tUseRs,
    output tTime_t              tUseRt,
    output logic                isHiLoMove,
    output logic                isMulDiv,
    output logic                isEret
);

    // Needed in decode, execute and memory respectively
    localparam tTime_t TUSE_D = tTime_t'(0);
    localparam tTime_t TUSE_E = tTime_t'(1);
    localparam tTime_t TUSE_M = tTime_t'(2);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] cop0Sel;
    regIdx_t    rsField;
    regIdx_t    rtField;

    assign opcode  = instrD[31:26];
    assign cop0Sel = instrD[25:21];
    assign rsField = instrD[25:21];
    assign rtField = instrD[20:16];
    assign funct   = instrD[5:0];

    //////////////////////////////////////////////////
    // One classification per instruction
    //////////////////////////////////////////////////

    always_comb begin
        srcRs      = '0;
        srcRt      = '0;
        tUseRs     = TUSE_D;
        tUseRt     = TUSE_D;
        isHiLoMove = 1'b0;
        isMulDiv   = 1'b0;
        isEret     = 1'b0;

        case (opcode)
            OP_R: begin
                case (funct)
                    FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_SLTU: begin
                        srcRs  = rsField;
                        srcRt  = rtField;
                        tUseRs = TUSE_E;
                        tUseRt = TUSE_E;
                    end
                    FN_MULT, FN_MULTU, FN_DIV, FN_DIVU: begin
                        srcRs    = rsField;
                        srcRt    = rtField;
                        tUseRs   = TUSE_E;
                        tUseRt   = TUSE_E;
                        isMulDiv = 1'b1;
                    end
                    FN_MTHI, FN_MTLO: begin
                        srcRs      = rsField;
                        tUseRs     = TUSE_E;
                        isHiLoMove = 1'b1;
                    end
                    // Reads HI/LO only, no GPR source
                    FN_MFHI, FN_MFLO: begin
                        isHiLoMove = 1'b1;
                    end
                    FN_JR: begin
                        srcRs  = rsField;
                        tUseRs = TUSE_D;
                    end
                    default: ;
                endcase
            end

            OP_ORI, OP_ADDI, OP_ANDI, OP_LW, OP_LH, OP_LB: begin
                srcRs  = rsField;
                tUseRs = TUSE_E;
            end

            // Base used for address, data only at memory
            OP_SW, OP_SH, OP_SB: begin
                srcRs  = rsField;
                srcRt  = rtField;
                tUseRs = TUSE_E;
                tUseRt = TUSE_M;
            end

            OP_BEQ, OP_BNE: begin
                srcRs  = rsField;
                srcRt  = rtField;
                tUseRs = TUSE_D;
                tUseRt = TUSE_D;
            end

            OP_COP0: begin
                if (cop0Sel == CP0_MT) begin
                    srcRt  = rtField;
                    tUseRt = TUSE_M;
                end else if (cop0Sel != CP0_MF && funct == FN_ERET) begin
                    isEret = 1'b1;
                end
            end

            // lui, j, jal read no register
            default: ;
        endcase
    end

endmodule

// File: hazard/newDecoder.sv
`timescale 1ns/1ps
`include "hazard_config.svh"

module newDecoder import hazardPkg::*; (
    input  logic [`INSTR_W-1:0] instrE,
    output regIdx_t             dstE,
    output tTime_t              tNewE
);

    // Cycles from execute until the result can be forwarded
    localparam tTime_t TNEW_NOW  = tTime_t'(0);
    localparam tTime_t TNEW_ALU  = tTime_t'(1);
    localparam tTime_t TNEW_LOAD = tTime_t'(2);

    localparam regIdx_t LINK_REG = regIdx_t'(31);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] cop0Sel;
    regIdx_t    rtField;
    regIdx_t    rdField;

    assign opcode  = instrE[31:26];
    assign cop0Sel = instrE[25:21];
    assign rtField = instrE[20:16];
    assign rdField = instrE[15:11];
    assign funct   = instrE[5:0];

    always_comb begin
        dstE  = '0;
        tNewE = TNEW_NOW;

        case (opcode)
            OP_R: begin
                case (funct)
                    FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_SLTU,
                    FN_MFHI, FN_MFLO: begin
                        dstE  = rdField;
                        tNewE = TNEW_ALU;
                    end
                    default: ;
                endcase
            end

            OP_ORI, OP_ADDI, OP_ANDI, OP_LUI: begin
                dstE  = rtField;
                tNewE = TNEW_ALU;
            end

            OP_LW, OP_LH, OP_LB: begin
                dstE  = rtField;
                tNewE = TNEW_LOAD;
            end

            // mfc0 value arrives with the memory stage
            OP_COP0: begin
                if (cop0Sel == CP0_MF) begin
                    dstE  = rtField;
                    tNewE = TNEW_LOAD;
                end
            end

            // Link address is ready already in execute
            OP_JAL: begin
                dstE  = LINK_REG;
                tNewE = TNEW_NOW;
            end

            default: ;
        endcase
    end

endmodule

// File: hazard/newTracker.sv
`timescale 1ns/1ps

module newTracker import hazardPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  regIdx_t dstE,
    input  tTime_t  tNewE,
    input  logic    regWriteE,
    output regIdx_t dstM,
    output tTime_t  tNewM,
    output logic    regWriteM
);

    tTime_t tNewAged;

    // One stage older, never below zero
    assign tNewAged = (tNewE == '0) ? '0 : tTime_t'(tNewE - tTime_t'(1));

    //////////////////////////////////////////////////
    // Memory-stage bookkeeping
    //////////////////////////////////////////////////

    // Memory stage always advances, stall does not hold it
    always_ff @(posedge clk) begin
        if (reset) begin
            dstM      <= '0;
            tNewM     <= '0;
            regWriteM <= 1'b0;
        end else begin
            dstM      <= dstE;
            tNewM     <= tNewAged;
            regWriteM <= regWriteE;
        end
    end

endmodule

// File: hazard/stallControl.sv
`timescale 1ns/1ps

module stallControl import hazardPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  regIdx_t srcRs,
    input  regIdx_t srcRt,
    input  tTime_t  tUseRs,
    input  tTime_t  tUseRt,
    input  logic    isHiLoMove,
    input  logic    isMulDiv,
    input  logic    isEret,
    input  regIdx_t dstE,
    input  tTime_t  tNewE,
    input  logic    regWriteE,
    input  regIdx_t dstM,
    input  tTime_t  tNewM,
    input  logic    regWriteM,
    input  logic    mduBusy,
    input  logic    mduStart,
    output logic    stall,
    output logic    mduBlock
);

    logic [1:0] eretCnt;
    logic       dataStall;
    logic       mduActive;
    logic       eretStall;

    // Source needed before the producer can forward it
    function automatic logic depStall(
        input regIdx_t src,
        input tTime_t  tUse,
        input regIdx_t dst,
        input logic    wr,
        input tTime_t  tNew
    );
        return (src != '0) && (src == dst) && wr && (tUse < tNew);
    endfunction

    //////////////////////////////////////////////////
    // Register dependencies
    //////////////////////////////////////////////////

    assign dataStall = depStall(srcRs, tUseRs, dstE, regWriteE, tNewE) |
                       depStall(srcRs, tUseRs, dstM, regWriteM, tNewM) |
                       depStall(srcRt, tUseRt, dstE, regWriteE, tNewE) |
                       depStall(srcRt, tUseRt, dstM, regWriteM, tNewM);

    //////////////////////////////////////////////////
    // MDU interlock
    //////////////////////////////////////////////////

    assign mduActive = mduBusy | mduStart;
    assign mduBlock  = isMulDiv & mduActive;

    //////////////////////////////////////////////////
    // eret hold
    //////////////////////////////////////////////////

    // Loaded with 1, counts down while eret waits in decode
    always_ff @(posedge clk) begin
        if (reset) begin
            eretCnt <= 2'd1;
        end else if (isEret) begin
            if (eretCnt != 2'd0) begin
                eretCnt <= eretCnt - 2'd1;
            end
        end else begin
            eretCnt <= 2'd1;
        end
    end

    assign eretStall = isEret && (eretCnt != 2'd0);

    assign stall = dataStall | (isHiLoMove & mduActive) | eretStall;

endmodule

// File: hazard/hazardUnit.sv
`timescale 1ns/1ps
`include "hazard_config.svh"

module hazardUnit import hazardPkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic [`INSTR_W-1:0] instrD,
    input  logic [`INSTR_W-1:0] instrE,
    input  logic                regWriteE,
    input  logic                mduBusy,
    input  logic                mduStart,
    output logic                pcWrite,
    output logic                ifIdEn,
    output logic                idExClr,
    output logic                mduBlock,
    output regIdx_t             srcRs,
    output regIdx_t             srcRt,
    output tTime_t              tNewE,
    output tTime_t              tNewM
);

    tTime_t  tUseRs;
    tTime_t  tUseRt;
    logic    isHiLoMove;
    logic    isMulDiv;
    logic    isEret;
    regIdx_t dstE;
    regIdx_t dstM;
    logic    regWriteM;
    logic    stall;

    // Decode stage sources
    useDecoder uUse (
        .instrD     (instrD),
        .srcRs      (srcRs),
        .srcRt      (srcRt),
        .tUseRs     (tUseRs),
        .tUseRt     (tUseRt),
        .isHiLoMove (isHiLoMove),
        .isMulDiv   (isMulDiv),
        .isEret     (isEret)
    );

    // Execute stage producer
    newDecoder uNew (
        .instrE (instrE),
        .dstE   (dstE),
        .tNewE  (tNewE)
    );

    newTracker uTrack (
        .clk       (clk),
        .reset     (reset),
        .dstE      (dstE),
        .tNewE     (tNewE),
        .regWriteE (regWriteE),
        .dstM      (dstM),
        .tNewM     (tNewM),
        .regWriteM (regWriteM)
    );

    stallControl uStall (
        .clk        (clk),
        .reset      (reset),
        .srcRs      (srcRs),
        .srcRt      (srcRt),
        .tUseRs     (tUseRs),
        .tUseRt     (tUseRt),
        .isHiLoMove (isHiLoMove),
        .isMulDiv   (isMulDiv),
        .isEret     (isEret),
        .dstE       (dstE),
        .tNewE      (tNewE),
        .regWriteE  (regWriteE),
        .dstM       (dstM),
        .tNewM      (tNewM),
        .regWriteM  (regWriteM),
        .mduBusy    (mduBusy),
        .mduStart   (mduStart),
        .stall      (stall),
        .mduBlock   (mduBlock)
    );

    // Freeze fetch and decode, bubble into execute
    assign pcWrite = ~stall;
    assign ifIdEn  = ~stall;
    assign idExClr = stall;

endmodule

// File: sim/hazardUnit_tb.sv
`timescale 1ns/1ps
`include "hazard_config.svh"

module hazardUnit_tb import hazardPkg::*; ();

    localparam int RESET_CYCLES = 8;
    localparam int MARGIN       = 20;
    localparam int FILLER_COUNT = 8;

    localparam logic [`INSTR_W-1:0] NOP  = '0;
    localparam logic [`INSTR_W-1:0] ERET = {OP_COP0, 5'b10000, 15'd0, FN_ERET};
    localparam logic [`INSTR_W-1:0] JAL  = {OP_JAL, 26'd0};

    typedef struct packed {
        logic [`INSTR_W-1:0] instrD;
        logic [`INSTR_W-1:0] instrE;
        logic                regWriteE;
        logic                mduBusy;
        logic                mduStart;
        logic                expStall;
        logic                expBlock;
        regIdx_t             expRs;
        regIdx_t             expRt;
        tTime_t              expTNewE;
    } stimEntry_t;

    logic                clk;
    logic                reset;
    logic [`INSTR_W-1:0] instrD;
    logic [`INSTR_W-1:0] instrE;
    logic                regWriteE;
    logic                mduBusy;
    logic                mduStart;
    logic                pcWrite;
    logic                ifIdEn;
    logic                idExClr;
    logic                mduBlock;
    regIdx_t             srcRs;
    regIdx_t             srcRt;
    tTime_t              tNewE;
    tTime_t              tNewM;

    stimEntry_t  stimTable[$];
    logic [31:0] lfsrState  = 32'h76feec3c;
    int          cycleCount = 0;
    int          cycleLimit = RESET_CYCLES + MARGIN;

    hazardUnit u_dut (
        .clk       (clk),
        .reset     (reset),
        .instrD    (instrD),
        .instrE    (instrE),
        .regWriteE (regWriteE),
        .mduBusy   (mduBusy),
        .mduStart  (mduStart),
        .pcWrite   (pcWrite),
        .ifIdEn    (ifIdEn),
        .idExClr   (idExClr),
        .mduBlock  (mduBlock),
        .srcRs     (srcRs),
        .srcRt     (srcRt),
        .tNewE     (tNewE),
        .tNewM     (tNewM)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic nextRandomBit();
        logic outBit;
        outBit = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ 32'h80200003;
        end
        return outBit;
    endfunction

    function automatic int randomReg();
        logic [4:0] r;
        int         n;
        r = '0;
        for (n = 0; n < 5; n++) begin
            r = {r[3:0], nextRandomBit()};
        end
        return int'(r);
    endfunction

    function automatic logic [`INSTR_W-1:0] rType(input logic [5:0] fn, input int rs,
                                                   input int rt, input int rd);
        return {OP_R, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic logic [`INSTR_W-1:0] iType(input logic [5:0] op, input int rs,
                                                   input int rt);
        return {op, 5'(rs), 5'(rt), 16'h0004};
    endfunction

    function automatic logic [`INSTR_W-1:0] cop0Move(input logic [4:0] sel, input int rt);
        return {OP_COP0, sel, 5'(rt), 5'd12, 11'd0};
    endfunction

    // M-stage Tnew is one cycle older, floor at zero
    function automatic tTime_t agedTime(input tTime_t t);
        return (t == '0) ? '0 : t - 2'd1;
    endfunction

    task automatic addEntry(input logic [`INSTR_W-1:0] dIn, input logic [`INSTR_W-1:0] eIn,
                            input int wr, input int busy, input int start, input int stl,
                            input int blk, input int rs, input int rt, input int tNew);
        stimEntry_t e;
        e.instrD    = dIn;
        e.instrE    = eIn;
        e.regWriteE = 1'(wr);
        e.mduBusy   = 1'(busy);
        e.mduStart  = 1'(start);
        e.expStall  = 1'(stl);
        e.expBlock  = 1'(blk);
        e.expRs     = 5'(rs);
        e.expRt     = 5'(rt);
        e.expTNewE  = 2'(tNew);
        stimTable.push_back(e);
    endtask

    task automatic abortRun();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on first failure");
    endtask

    task automatic checkField(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error [%0t] %s: got %0h, expected %0h", $time, name, got, exp);
            abortRun();
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus table
    //////////////////////////////////////////////////

    // Columns: D, E, wrE, busy, start | stall, mduBlock, rs, rt, tNewE
    task automatic buildTable();
        int k;
        int a;
        int b;
        int d;
        addEntry(NOP, NOP, 0, 0, 0, 0, 0, 0, 0, 0);
        // Load-use on E stage, store data, branch on ALU result
        addEntry(rType(FN_ADD, 8, 5, 9), iType(OP_LW, 4, 8), 1, 0, 0, 1, 0, 8, 5, 2);
        addEntry(iType(OP_SW, 4, 8), iType(OP_LW, 4, 8), 1, 0, 0, 0, 0, 4, 8, 2);
        addEntry(iType(OP_BEQ, 10, 0), rType(FN_ADD, 2, 3, 10), 1, 0, 0, 1, 0, 10, 0, 1);
        // Load ages into M with Tnew 1
        addEntry(NOP, iType(OP_LW, 0, 12), 1, 0, 0, 0, 0, 0, 0, 2);
        addEntry(iType(OP_BEQ, 12, 0), NOP, 0, 0, 0, 1, 0, 12, 0, 0);
        addEntry(NOP, iType(OP_LW, 0, 12), 1, 0, 0, 0, 0, 0, 0, 2);
        addEntry(rType(FN_ADD, 12, 12, 13), NOP, 0, 0, 0, 0, 0, 12, 12, 0);
        // Register 0 never stalls
        addEntry(NOP, iType(OP_LW, 4, 0), 1, 0, 0, 0, 0, 0, 0, 2);
        addEntry(rType(FN_ADD, 0, 0, 1), iType(OP_LW, 4, 0), 1, 0, 0, 0, 0, 0, 0, 2);
        addEntry(iType(OP_BEQ, 0, 0), iType(OP_LW, 4, 0), 1, 0, 0, 0, 0, 0, 0, 2);
        // Match without write enable
        addEntry(rType(FN_ADD, 8, 5, 9), iType(OP_LW, 4, 8), 0, 0, 0, 0, 0, 8, 5, 2);
        // Source export
        addEntry(iType(OP_LUI, 3, 7), NOP, 0, 0, 0, 0, 0, 0, 0, 0);
        addEntry(iType(OP_SW, 5, 6), NOP, 0, 0, 0, 0, 0, 5, 6, 0);
        addEntry(iType(OP_ORI, 2, 3), NOP, 0, 0, 0, 0, 0, 2, 0, 0);
        addEntry(rType(FN_JR, 31, 0, 0), JAL, 1, 0, 0, 0, 0, 31, 0, 0);
        addEntry(cop0Move(CP0_MT, 5), cop0Move(CP0_MF, 5), 1, 0, 0, 0, 0, 0, 5, 2);
        // MDU interlock
        addEntry(rType(FN_MFHI, 0, 0, 4), NOP, 0, 1, 0, 1, 0, 0, 0, 0);
        addEntry(rType(FN_MFLO, 0, 0, 4), NOP, 0, 0, 1, 1, 0, 0, 0, 0);
        addEntry(rType(FN_MULT, 2, 3, 0), NOP, 0, 1, 0, 0, 1, 2, 3, 0);
        addEntry(rType(FN_DIVU, 4, 5, 0), NOP, 0, 0, 1, 0, 1, 4, 5, 0);
        addEntry(rType(FN_MFHI, 0, 0, 4), NOP, 0, 0, 0, 0, 0, 0, 0, 0);
        addEntry(rType(FN_MULT, 2, 3, 0), NOP, 0, 0, 0, 0, 0, 2, 3, 0);
        addEntry(rType(FN_MTHI, 6, 0, 0), NOP, 0, 1, 0, 1, 0, 6, 0, 0);
        // eret held one cycle, counter reloads after it leaves
        addEntry(ERET, NOP, 0, 0, 0, 1, 0, 0, 0, 0);
        addEntry(ERET, NOP, 0, 0, 0, 0, 0, 0, 0, 0);
        addEntry(NOP, NOP, 0, 0, 0, 0, 0, 0, 0, 0);
        addEntry(ERET, NOP, 0, 0, 0, 1, 0, 0, 0, 0);
        addEntry(ERET, NOP, 0, 0, 0, 0, 0, 0, 0, 0);
        // ALU to ALU on a shared register is always forwardable
        for (k = 0; k < FILLER_COUNT; k++) begin
            a = randomReg();
            b = randomReg();
            d = randomReg();
            addEntry(rType(FN_ADD, a, b, 1), iType(OP_ORI, d, a), 1, 0, 0, 0, 0, a, b, 1);
        end
    endtask

    //////////////////////////////////////////////////
    // Run
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: run exceeded %0d cycles", cycleLimit);
            abortRun();
        end
    end

    initial begin
        stimEntry_t cur;
        tTime_t     prevTNewE;
        int         i;
        reset     <= 1'b1;
        instrD    <= NOP;
        instrE    <= NOP;
        regWriteE <= 1'b0;
        mduBusy   <= 1'b0;
        mduStart  <= 1'b0;
        prevTNewE = '0;
        buildTable();
        cycleLimit = RESET_CYCLES + stimTable.size() + MARGIN;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        for (i = 0; i < stimTable.size(); i++) begin
            @(posedge clk);
            cur = stimTable[i];
            instrD    <= cur.instrD;
            instrE    <= cur.instrE;
            regWriteE <= cur.regWriteE;
            mduBusy   <= cur.mduBusy;
            mduStart  <= cur.mduStart;
            // Outputs settled mid-cycle
            @(negedge clk);
            checkField("pcWrite", 32'(pcWrite), 32'(!cur.expStall));
            checkField("ifIdEn", 32'(ifIdEn), 32'(!cur.expStall));
            checkField("idExClr", 32'(idExClr), 32'(cur.expStall));
            checkField("mduBlock", 32'(mduBlock), 32'(cur.expBlock));
            checkField("srcRs", 32'(srcRs), 32'(cur.expRs));
            checkField("srcRt", 32'(srcRt), 32'(cur.expRt));
            checkField("tNewE", 32'(tNewE), 32'(cur.expTNewE));
            checkField("tNewM", 32'(tNewM), 32'(agedTime(prevTNewE)));
            prevTNewE = cur.expTNewE;
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: sim.f
+incdir+common
common/hazardPkg.sv
hazard/useDecoder.sv
hazard/newDecoder.sv
hazard/newTracker.sv
hazard/stallControl.sv
hazard/hazardUnit.sv
sim/hazardUnit_tb.sv

// File: Makefile
# Verilator build for the hazard unit testbench

VERILATOR ?= verilator
TOP       ?= hazardUnit_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
EXTRA     ?=

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A $fatal in the testbench gives a nonzero exit status
run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
